/* rtl/chiplet_pkg.sv */
`default_nettype none

package chiplet_pkg;

    // data and address sizes.
    localparam int WORD_WIDTH       = 32;
    localparam int ADDR_WIDTH       = 8;
    localparam int PKT_LENGTH_WIDTH = 8;
    localparam int MSG_ID_WIDTH     = 2;
    localparam int NODE_ID_WIDTH    = 4;
    localparam int VC_WIDTH         = 1;

    // flit fields from msb to lsb are vc, id, req and payload.
    localparam int FLIT_PAYLOAD_LSB = 0;
    localparam int FLIT_REQ_LSB     = FLIT_PAYLOAD_LSB + WORD_WIDTH;
    localparam int FLIT_ID_LSB      = FLIT_REQ_LSB + NODE_ID_WIDTH;
    localparam int FLIT_VC_LSB      = FLIT_ID_LSB + MSG_ID_WIDTH;
    localparam int FLIT_WIDTH       = FLIT_VC_LSB + VC_WIDTH;

    // crc-32 taken msb first with no reflection and no final xor.
    localparam logic [WORD_WIDTH-1:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [WORD_WIDTH-1:0] CRC_POLY = 32'h04C1_1DB7;

    typedef enum logic [1:0] {
        IDLE,
        START_SEND_PKT,
        SEND_PKT,
        CRC
    } tx_state_e;

    // payload word count in the header plus the header itself.
    function automatic logic [PKT_LENGTH_WIDTH-1:0] expected_num_flits(
        input logic [WORD_WIDTH-1:0] header
    );
        return header[PKT_LENGTH_WIDTH-1:0] + 1'b1;
    endfunction

endpackage

`default_nettype wire

/* rtl/msg_table.sv */
`timescale 1ns/100ps
`default_nettype none

module msg_table #(
    parameter int NUM_MSGS = 4
) (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic                                 tbl_wen,
    input  logic [chiplet_pkg::MSG_ID_WIDTH-1:0] tbl_idx,
    input  logic [chiplet_pkg::ADDR_WIDTH-1:0]   tbl_addr,
    input  logic [NUM_MSGS-1:0]                  trigger,
    input  logic                                 accept,
    output logic [NUM_MSGS-1:0]                  pending,
    output logic [chiplet_pkg::MSG_ID_WIDTH-1:0] sel_id,
    output logic [chiplet_pkg::ADDR_WIDTH-1:0]   sel_addr
);

    logic [chiplet_pkg::ADDR_WIDTH-1:0] start_addr [NUM_MSGS];
    logic [NUM_MSGS-1:0]                retire;

    always_ff @(posedge clk) begin
        if (tbl_wen) begin
            start_addr[tbl_idx] <= tbl_addr;
        end
    end

    // highest pending index wins.
    always_comb begin
        sel_id = '0;
        for (int i = 0; i < NUM_MSGS; i++) begin
            if (pending[i]) begin
                sel_id = i[chiplet_pkg::MSG_ID_WIDTH-1:0];
            end
        end
        sel_addr = start_addr[sel_id];
    end

    always_comb begin
        retire = '0;
        if (accept) begin
            retire[sel_id] = 1'b1;
        end
    end

    // a new trigger beats retirement.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~retire) | trigger;
        end
    end

    a_accept_pending: assert property (@(posedge clk) disable iff (!n_rst)
        accept |-> |pending);

endmodule

`default_nettype wire

/* rtl/pkt_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_mem (
    input  logic                               clk,
    input  logic                               n_rst,
    input  logic                               mem_wen,
    input  logic [chiplet_pkg::ADDR_WIDTH-1:0] mem_waddr,
    input  logic [chiplet_pkg::WORD_WIDTH-1:0] mem_wdata,
    input  logic                               rd_en,
    input  logic [chiplet_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic [chiplet_pkg::WORD_WIDTH-1:0] rd_data,
    output logic                               rd_stall
);

    logic [chiplet_pkg::WORD_WIDTH-1:0] mem [2**chiplet_pkg::ADDR_WIDTH];
    logic [chiplet_pkg::ADDR_WIDTH-1:0] last_addr;
    logic                               last_valid;
    logic                               wr_hit;

    // host write to the word being read makes it stale.
    assign wr_hit = mem_wen && (mem_waddr == rd_addr);

    always_ff @(posedge clk) begin
        if (mem_wen) begin
            mem[mem_waddr] <= mem_wdata;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            last_addr  <= '0;
            last_valid <= 1'b0;
        end else begin
            last_valid <= rd_en && !wr_hit;
            if (rd_en) begin
                last_addr <= rd_addr;
            end
        end
    end

    // data is good once the same address was read last cycle.
    assign rd_stall = !last_valid || (rd_addr != last_addr);

endmodule

`default_nettype wire

/* rtl/flit_crc.sv */
`timescale 1ns/100ps
`default_nettype none

module flit_crc (
    input  logic                               clk,
    input  logic                               n_rst,
    input  logic                               crc_clear,
    input  logic                               crc_update,
    input  logic [chiplet_pkg::WORD_WIDTH-1:0] crc_in,
    output logic [chiplet_pkg::WORD_WIDTH-1:0] crc_value,
    output logic                               crc_ready
);

    logic [chiplet_pkg::WORD_WIDTH-1:0] crc_q;
    logic [chiplet_pkg::WORD_WIDTH-1:0] word_q;
    logic [1:0]                         byte_cnt;
    logic                               folding;

    function automatic logic [31:0] crc_byte_step(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {data, 24'h0};
        for (int b = 0; b < 8; b++) begin
            c = c[31] ? ((c << 1) ^ chiplet_pkg::CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_q    <= chiplet_pkg::CRC_INIT;
            folding  <= 1'b0;
            byte_cnt <= '0;
        end else if (crc_clear) begin
            crc_q    <= chiplet_pkg::CRC_INIT;
            folding  <= 1'b0;
            byte_cnt <= '0;
        end else if (crc_update && !folding) begin
            folding  <= 1'b1;
            byte_cnt <= '0;
        end else if (folding) begin
            crc_q    <= crc_byte_step(crc_q, word_q[31:24]);
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
                folding <= 1'b0;
            end
        end
    end

    // most significant byte first.
    always_ff @(posedge clk) begin
        if (crc_update && !folding) begin
            word_q <= crc_in;
        end else if (folding) begin
            word_q <= word_q << 8;
        end
    end

    assign crc_value = crc_q;
    assign crc_ready = !folding;

    a_update_when_ready: assert property (@(posedge clk) disable iff (!n_rst)
        crc_update |-> crc_ready);

endmodule

`default_nettype wire

/* rtl/tx_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_fsm #(
    parameter int NUM_MSGS = 4,
    parameter int DEPTH    = 8,
    parameter int NODE_ID  = 3
) (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic [NUM_MSGS-1:0]                  pending,
    input  logic [chiplet_pkg::MSG_ID_WIDTH-1:0] sel_id,
    input  logic [chiplet_pkg::ADDR_WIDTH-1:0]   sel_addr,
    output logic                                 accept,
    output logic                                 rd_en,
    output logic [chiplet_pkg::ADDR_WIDTH-1:0]   rd_addr,
    input  logic [chiplet_pkg::WORD_WIDTH-1:0]   rd_data,
    input  logic                                 rd_stall,
    output logic                                 crc_clear,
    output logic                                 crc_update,
    output logic [chiplet_pkg::WORD_WIDTH-1:0]   crc_in,
    input  logic [chiplet_pkg::WORD_WIDTH-1:0]   crc_value,
    input  logic                                 crc_ready,
    input  logic                                 credit_return,
    output logic                                 flit_valid,
    output logic [chiplet_pkg::FLIT_WIDTH-1:0]   flit,
    output logic                                 busy
);

    localparam int LIMIT = 3 * DEPTH / 4;

    chiplet_pkg::tx_state_e state, next_state;

    logic [chiplet_pkg::MSG_ID_WIDTH-1:0]     msg_id_q;
    logic [chiplet_pkg::ADDR_WIDTH-1:0]       base_addr_q;
    logic [chiplet_pkg::PKT_LENGTH_WIDTH-1:0] pkt_len;
    logic [chiplet_pkg::PKT_LENGTH_WIDTH-1:0] flit_idx;
    logic [chiplet_pkg::PKT_LENGTH_WIDTH-1:0] sent_cnt;
    logic                                     credit_ok;
    logic                                     last_word;
    logic                                     send;

    assign credit_ok = (sent_cnt != chiplet_pkg::PKT_LENGTH_WIDTH'(LIMIT));
    assign last_word = (flit_idx == pkt_len - 1'b1);
    assign rd_addr   = base_addr_q + chiplet_pkg::ADDR_WIDTH'(flit_idx);

    always_comb begin
        next_state = state;
        accept     = 1'b0;
        crc_clear  = 1'b0;
        rd_en      = 1'b0;
        send       = 1'b0;
        case (state)
            chiplet_pkg::IDLE: begin
                crc_clear = 1'b1;
                if (|pending) begin
                    accept     = 1'b1;
                    next_state = chiplet_pkg::START_SEND_PKT;
                end
            end
            chiplet_pkg::START_SEND_PKT: begin
                rd_en = 1'b1;
                if (!rd_stall) begin
                    next_state = chiplet_pkg::SEND_PKT;
                end
            end
            chiplet_pkg::SEND_PKT: begin
                rd_en = 1'b1;
                if (!rd_stall && crc_ready && credit_ok) begin
                    send = 1'b1;
                    if (last_word) begin
                        next_state = chiplet_pkg::CRC;
                    end
                end
            end
            chiplet_pkg::CRC: begin
                if (crc_ready && credit_ok) begin
                    send       = 1'b1;
                    next_state = chiplet_pkg::IDLE;
                end
            end
            default: next_state = chiplet_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= chiplet_pkg::IDLE;
            pkt_len  <= '0;
            flit_idx <= '0;
            sent_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == chiplet_pkg::START_SEND_PKT && !rd_stall) begin
                pkt_len <= chiplet_pkg::expected_num_flits(rd_data);
            end
            if (accept) begin
                flit_idx <= '0;
            end else if (crc_update) begin
                flit_idx <= flit_idx + 1'b1;
            end
            // switch buffer drained.
            if (credit_return) begin
                sent_cnt <= send ? chiplet_pkg::PKT_LENGTH_WIDTH'(1) : '0;
            end else if (send) begin
                sent_cnt <= sent_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            msg_id_q    <= sel_id;
            base_addr_q <= sel_addr;
        end
    end

    assign crc_update = send && (state == chiplet_pkg::SEND_PKT);
    assign crc_in     = rd_data;
    assign flit_valid = send;
    assign busy       = (state != chiplet_pkg::IDLE);

    // only vc 0 is used.
    always_comb begin
        flit = '0;
        flit[chiplet_pkg::FLIT_VC_LSB +: chiplet_pkg::VC_WIDTH] = '0;
        flit[chiplet_pkg::FLIT_ID_LSB +: chiplet_pkg::MSG_ID_WIDTH] = msg_id_q;
        flit[chiplet_pkg::FLIT_REQ_LSB +: chiplet_pkg::NODE_ID_WIDTH] =
            chiplet_pkg::NODE_ID_WIDTH'(NODE_ID);
        flit[chiplet_pkg::FLIT_PAYLOAD_LSB +: chiplet_pkg::WORD_WIDTH] =
            (state == chiplet_pkg::CRC) ? crc_value : rd_data;
    end

    a_credit_limit: assert property (@(posedge clk) disable iff (!n_rst)
        flit_valid |-> sent_cnt < chiplet_pkg::PKT_LENGTH_WIDTH'(LIMIT));

endmodule

`default_nettype wire

/* rtl/tx_endpoint.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_endpoint #(
    parameter int NUM_MSGS = 4,
    parameter int DEPTH    = 8,
    parameter int NODE_ID  = 3
) (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic                                 mem_wen,
    input  logic [chiplet_pkg::ADDR_WIDTH-1:0]   mem_waddr,
    input  logic [chiplet_pkg::WORD_WIDTH-1:0]   mem_wdata,
    input  logic                                 tbl_wen,
    input  logic [chiplet_pkg::MSG_ID_WIDTH-1:0] tbl_idx,
    input  logic [chiplet_pkg::ADDR_WIDTH-1:0]   tbl_addr,
    input  logic [NUM_MSGS-1:0]                  trigger,
    input  logic                                 credit_return,
    output logic                                 flit_valid,
    output logic [chiplet_pkg::FLIT_WIDTH-1:0]   flit,
    output logic                                 busy
);

    logic [NUM_MSGS-1:0]                  pending;
    logic [chiplet_pkg::MSG_ID_WIDTH-1:0] sel_id;
    logic [chiplet_pkg::ADDR_WIDTH-1:0]   sel_addr, rd_addr;
    logic [chiplet_pkg::WORD_WIDTH-1:0]   rd_data, crc_in, crc_value;
    logic                                 accept, rd_en, rd_stall;
    logic                                 crc_clear, crc_update, crc_ready;

    msg_table #(.NUM_MSGS(NUM_MSGS)) table0 (
        .clk, .n_rst, .tbl_wen, .tbl_idx, .tbl_addr, .trigger, .accept,
        .pending, .sel_id, .sel_addr
    );

    pkt_mem mem0 (
        .clk, .n_rst, .mem_wen, .mem_waddr, .mem_wdata, .rd_en, .rd_addr,
        .rd_data, .rd_stall
    );

    flit_crc crc0 (
        .clk, .n_rst, .crc_clear, .crc_update, .crc_in, .crc_value, .crc_ready
    );

    tx_fsm #(.NUM_MSGS(NUM_MSGS), .DEPTH(DEPTH), .NODE_ID(NODE_ID)) fsm0 (
        .clk, .n_rst, .pending, .sel_id, .sel_addr, .accept, .rd_en, .rd_addr,
        .rd_data, .rd_stall, .crc_clear, .crc_update, .crc_in, .crc_value,
        .crc_ready, .credit_return, .flit_valid, .flit, .busy
    );

endmodule

`default_nettype wire

/* test/tx_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_checker #(
    parameter int NODE_ID = 3
) (
    input logic                               clk,
    input logic                               flit_valid,
    input logic [chiplet_pkg::FLIT_WIDTH-1:0] flit,
    input logic                               busy
);

    logic [chiplet_pkg::FLIT_WIDTH-1:0] exp_q [$];
    logic [chiplet_pkg::FLIT_WIDTH-1:0] exp_flit;
    logic [31:0]                        staged [$];
    string test_name = "none";
    int    test_errors = 0;
    int    flit_num = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    // crc-32 over whole words one bit at a time with the msb first.
    function automatic logic [31:0] ref_crc(input logic [31:0] words [$]);
        logic [31:0] c;
        logic        fb;
        c = 32'hFFFF_FFFF;
        foreach (words[i]) begin
            for (int b = 31; b >= 0; b--) begin
                fb = c[31] ^ words[i][b];
                c  = c << 1;
                if (fb) begin
                    c = c ^ 32'h04C1_1DB7;
                end
            end
        end
        return c;
    endfunction

    // vc 0, message id, requesting node, payload.
    function automatic logic [chiplet_pkg::FLIT_WIDTH-1:0] ref_flit(
        input logic [1:0]  id,
        input logic [31:0] payload
    );
        return {1'b0, id, 4'(NODE_ID), payload};
    endfunction

    task automatic stage_word(input logic [31:0] w);
        staged.push_back(w);
    endtask

    task automatic expect_message(input logic [1:0] id);
        foreach (staged[i]) begin
            exp_q.push_back(ref_flit(id, staged[i]));
        end
        exp_q.push_back(ref_flit(id, ref_crc(staged)));
        staged.delete();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        flit_num    = 0;
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
    endtask

    task automatic finish_test();
        if (exp_q.size() != 0) begin
            report_problem($sformatf("%0d expected flits never arrived", exp_q.size()));
            exp_q.delete();
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end else begin
            $display("test %s: passed, %0d flits", test_name, flit_num);
        end
    endtask

    function automatic int remaining();
        return exp_q.size();
    endfunction

    function automatic int flits_seen();
        return flit_num;
    endfunction

    function automatic int failed_count();
        return tests_failed;
    endfunction

    task automatic print_counts();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
    endtask

    always @(negedge clk) begin
        if (flit_valid) begin
            if (!busy) begin
                report_problem("flit_valid high while busy is low");
            end
            if (exp_q.size() == 0) begin
                report_problem($sformatf("extra flit %h with nothing expected", flit));
            end else begin
                exp_flit = exp_q.pop_front();
                if (flit !== exp_flit) begin
                    $display("Fail %s: flit %0d expected %h actual %h",
                             test_name, flit_num, exp_flit, flit);
                    test_errors++;
                end
            end
            flit_num++;
        end
    end

endmodule

`default_nettype wire

/* test/tb_tx_endpoint.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tx_endpoint;

    localparam int NUM_MSGS = 4;
    localparam int DEPTH    = 8;
    localparam int NODE_ID  = 3;

    logic                                 clk = 1'b0;
    logic                                 n_rst = 1'b0;
    logic                                 mem_wen = 1'b0;
    logic [chiplet_pkg::ADDR_WIDTH-1:0]   mem_waddr = '0;
    logic [chiplet_pkg::WORD_WIDTH-1:0]   mem_wdata = '0;
    logic                                 tbl_wen = 1'b0;
    logic [chiplet_pkg::MSG_ID_WIDTH-1:0] tbl_idx = '0;
    logic [chiplet_pkg::ADDR_WIDTH-1:0]   tbl_addr = '0;
    logic [NUM_MSGS-1:0]                  trigger = '0;
    logic                                 credit_return = 1'b0;
    logic                                 flit_valid;
    logic [chiplet_pkg::FLIT_WIDTH-1:0]   flit;
    logic                                 busy;

    int   seed = 79;
    int   flits_out = 0;
    int   credit_gap = 4;
    logic hold_credit = 1'b0;
    logic timed_out = 1'b0;

    tx_endpoint #(.NUM_MSGS(NUM_MSGS), .DEPTH(DEPTH), .NODE_ID(NODE_ID)) dut0 (
        .clk, .n_rst, .mem_wen, .mem_waddr, .mem_wdata, .tbl_wen, .tbl_idx,
        .tbl_addr, .trigger, .credit_return, .flit_valid, .flit, .busy
    );

    tx_checker #(.NODE_ID(NODE_ID)) chk0 (.clk, .flit_valid, .flit, .busy);

    initial begin
        forever #4 clk = ~clk;
    end

    // switch model that mirrors the sent count and drains after credit_gap flits.
    always @(posedge clk) begin
        if (credit_return) begin
            flits_out = 0;
        end
        if (flit_valid) begin
            flits_out++;
        end
        credit_return <= !hold_credit && !credit_return && (flits_out >= credit_gap);
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic note_timeout(input string what);
        chk0.report_problem($sformatf("timed out %s", what));
        timed_out = 1'b1;
    endtask

    // header low byte holds the payload length.
    task automatic load_message(input logic [1:0] id, input logic [7:0] addr, input int len);
        logic [31:0] w;
        for (int i = 0; i <= len; i++) begin
            w = $random(seed);
            if (i == 0) begin
                w[7:0] = len[7:0];
            end
            @(posedge clk);
            mem_wen   <= 1'b1;
            mem_waddr <= addr + 8'(i);
            mem_wdata <= w;
            chk0.stage_word(w);
        end
        @(posedge clk);
        mem_wen  <= 1'b0;
        tbl_wen  <= 1'b1;
        tbl_idx  <= id;
        tbl_addr <= addr;
        @(posedge clk);
        tbl_wen <= 1'b0;
        chk0.expect_message(id);
    endtask

    task automatic raise_trigger(input logic [NUM_MSGS-1:0] bits);
        @(posedge clk);
        trigger <= bits;
        @(posedge clk);
        trigger <= '0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!timed_out && (chk0.remaining() != 0 || busy)) begin
            step();
            n++;
            if (n == limit) begin
                note_timeout("waiting for the packets to finish");
            end
        end
        repeat (20) step();
    endtask

    task automatic wait_flits(input int count, input int limit);
        int n;
        n = 0;
        while (!timed_out && chk0.flits_seen() < count) begin
            step();
            n++;
            if (n == limit) begin
                note_timeout("waiting for flits to appear");
            end
        end
    endtask

    // return every outstanding credit so the next test starts from zero.
    task automatic drain_credit();
        int n;
        n = 0;
        credit_gap = 1;
        while (!timed_out && flits_out != 0) begin
            step();
            n++;
            if (n == 100) begin
                note_timeout("returning credit");
            end
        end
        credit_gap = 4;
    endtask

    initial begin
        logic [1:0] id;
        logic [7:0] addr;
        int         len;

        repeat (8) @(posedge clk);
        n_rst <= 1'b1;

        chk0.start_test("reset state");
        for (int i = 0; i < 20; i++) begin
            step();
            if (busy || flit_valid) begin
                chk0.report_problem("busy or flit_valid high with no trigger");
            end
        end
        chk0.finish_test();

        chk0.start_test("single packet");
        load_message(2'd1, 8'h10, 3);
        raise_trigger(4'b0010);
        wait_done(2000);
        chk0.finish_test();

        chk0.start_test("header only");
        load_message(2'd2, 8'h30, 0);
        raise_trigger(4'b0100);
        wait_done(2000);
        chk0.finish_test();

        // highest index goes first.
        chk0.start_test("priority and retirement");
        load_message(2'd3, 8'h80, 2);
        load_message(2'd2, 8'h60, 4);
        load_message(2'd0, 8'h40, 1);
        raise_trigger(4'b1101);
        wait_done(4000);
        chk0.finish_test();

        chk0.start_test("credit back-pressure");
        drain_credit();
        hold_credit = 1'b1;
        load_message(2'd1, 8'h20, 10);
        raise_trigger(4'b0010);
        wait_flits(3 * DEPTH / 4, 1000);
        repeat (40) step();
        if (chk0.flits_seen() != 3 * DEPTH / 4) begin
            chk0.report_problem("flits kept coming with no credit returned");
        end
        if (!busy) begin
            chk0.report_problem("controller went idle with the packet unfinished");
        end
        hold_credit = 1'b0;
        wait_done(2000);
        chk0.finish_test();

        chk0.start_test("random traffic");
        for (int p = 0; p < 10; p++) begin
            id         = 2'($unsigned($random(seed)) % 4);
            addr       = 8'($random(seed));
            len        = int'($unsigned($random(seed)) % 13);
            credit_gap = 2 + int'($unsigned($random(seed)) % 5);
            load_message(id, addr, len);
            raise_trigger(NUM_MSGS'(1) << id);
            wait_done(2000);
        end
        chk0.finish_test();

        chk0.print_counts();
        if (timed_out || chk0.failed_count() != 0) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/chiplet_pkg.sv
rtl/msg_table.sv
rtl/pkt_mem.sv
rtl/flit_crc.sv
rtl/tx_fsm.sv
rtl/tx_endpoint.sv
test/tx_checker.sv
test/tb_tx_endpoint.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_tx_endpoint
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
